/* source/cpu_params.svh */
// memory depths, reset PC, LED address and instruction field encodings
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256
`define CPU_RESET_PC 32'h0000_0000
`define CPU_LED_ADDR 32'h0000_1000
`define CPU_LED_WIDTH 16

`define CPU_OP_RTYPE 6'h00
`define CPU_OP_J 6'h02
`define CPU_OP_BEQ 6'h04
`define CPU_OP_BNE 6'h05
`define CPU_OP_ADDIU 6'h09
`define CPU_OP_ORI 6'h0d
`define CPU_OP_LUI 6'h0f
`define CPU_OP_LW 6'h23
`define CPU_OP_SW 6'h2b

`define CPU_FN_BREAK 6'h0d
`define CPU_FN_ADDU 6'h21
`define CPU_FN_SUBU 6'h23
`define CPU_FN_AND 6'h24
`define CPU_FN_OR 6'h25
`define CPU_FN_XOR 6'h26
`define CPU_FN_SLT 6'h2a

`endif

/* source/cpu_pkg.sv */
// word and index types, ALU operation enum and the pipeline stage structs
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [7:0] imem_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI    // passes operand b
    } alu_op_e;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        word_t     st_data;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t dest;
        logic      is_break;
    } dec_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     alu_res;    // also the memory byte address
        word_t     st_data;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t dest;
        logic      is_break;
    } ex_res_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

endpackage

/* source/reg_file.sv */
// 32-entry register file with write-through bypass and a view port
`timescale 1ns/1ns

module reg_file (
    input  logic               clk,
    input  logic               resetn,
    input  cpu_pkg::reg_addr_t rs_addr_i,
    input  cpu_pkg::reg_addr_t rt_addr_i,
    input  cpu_pkg::wb_t       wb_i,
    input  cpu_pkg::reg_addr_t view_sel_i,
    output cpu_pkg::word_t     rs_data_o,
    output cpu_pkg::word_t     rt_data_o,
    output cpu_pkg::word_t     view_data_o
);
    import cpu_pkg::*;

    localparam int NUM_REGS = 32;

    word_t regs_q [NUM_REGS];

    // r0 reads zero, a write in the same cycle wins over the stored value
    function automatic word_t read_port(reg_addr_t addr, wb_t wb, word_t stored);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wb.we && wb.addr == addr) begin
            val = wb.data;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && wb_i.addr != '0) begin
            regs_q[wb_i.addr] <= wb_i.data;
        end
    end

    assign rs_data_o   = read_port(rs_addr_i, wb_i, regs_q[rs_addr_i]);
    assign rt_data_o   = read_port(rt_addr_i, wb_i, regs_q[rt_addr_i]);
    assign view_data_o = read_port(view_sel_i, wb_i, regs_q[view_sel_i]);

endmodule

/* source/decode_stage.sv */
// PC, instruction memory, decoder, operand forwarding, branch resolution, halt latch
`timescale 1ns/1ns
`include "cpu_params.svh"

module decode_stage (
    input  logic                clk,
    input  logic                resetn,
    input  logic                prog_we_i,
    input  cpu_pkg::imem_addr_t prog_addr_i,
    input  cpu_pkg::word_t      prog_data_i,
    input  cpu_pkg::word_t      rs_data_i,
    input  cpu_pkg::word_t      rt_data_i,
    input  cpu_pkg::fwd_t       ex_fwd_i,
    input  cpu_pkg::fwd_t       res_fwd_i,
    output cpu_pkg::reg_addr_t  rs_addr_o,
    output cpu_pkg::reg_addr_t  rt_addr_o,
    output cpu_pkg::dec_ex_t    dec_ex_o
);
    import cpu_pkg::*;

    word_t      imem_q [`CPU_IMEM_DEPTH];
    word_t      pc_q;
    logic       halt_q;
    dec_ex_t    dec_ex_q;
    imem_addr_t fetch_idx;
    word_t      instr;
    word_t      pc_plus4;
    word_t      rs_val;
    word_t      rt_val;
    word_t      imm_val;
    alu_op_e    alu_op;
    reg_addr_t  dest;
    logic       use_imm, reg_write, mem_read, mem_write;
    logic       is_break, is_beq, is_bne, is_j;
    logic       issue;
    logic       taken;
    word_t      br_target;
    word_t      j_target;

    // newest producer first, r0 is never forwarded
    function automatic word_t pick_operand(reg_addr_t r, fwd_t ex_f, fwd_t res_f,
                                           word_t rf_val);
        word_t val;
        if (r == '0) begin
            val = '0;
        end else if (ex_f.we && ex_f.addr == r) begin
            val = ex_f.data;
        end else if (res_f.we && res_f.addr == r) begin
            val = res_f.data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (prog_we_i) begin
            imem_q[prog_addr_i] <= prog_data_i;  // program load during reset
        end
    end

    assign fetch_idx = pc_q[$bits(imem_addr_t)+1:2];
    assign instr     = imem_q[fetch_idx];
    assign pc_plus4  = pc_q + 32'd4;
    assign rs_addr_o = instr[25:21];
    assign rt_addr_o = instr[20:16];

    assign rs_val = pick_operand(rs_addr_o, ex_fwd_i, res_fwd_i, rs_data_i);
    assign rt_val = pick_operand(rt_addr_o, ex_fwd_i, res_fwd_i, rt_data_i);

    always_comb begin
        alu_op    = ALU_ADD;
        imm_val   = {{16{instr[15]}}, instr[15:0]};
        dest      = instr[15:11];  // rd
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_break  = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (instr[31:26])
            `CPU_OP_RTYPE: begin
                reg_write = 1'b1;
                case (instr[5:0])
                    `CPU_FN_ADDU: alu_op = ALU_ADD;
                    `CPU_FN_SUBU: alu_op = ALU_SUB;
                    `CPU_FN_AND:  alu_op = ALU_AND;
                    `CPU_FN_OR:   alu_op = ALU_OR;
                    `CPU_FN_XOR:  alu_op = ALU_XOR;
                    `CPU_FN_SLT:  alu_op = ALU_SLT;
                    `CPU_FN_BREAK: begin
                        reg_write = 1'b0;
                        is_break  = 1'b1;
                    end
                    default: reg_write = 1'b0;  // nop and unsupported
                endcase
            end
            `CPU_OP_ADDIU: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                dest      = instr[20:16];
            end
            `CPU_OP_ORI: begin
                alu_op    = ALU_OR;
                imm_val   = {16'h0000, instr[15:0]};
                use_imm   = 1'b1;
                reg_write = 1'b1;
                dest      = instr[20:16];
            end
            `CPU_OP_LUI: begin
                alu_op    = ALU_LUI;
                imm_val   = {instr[15:0], 16'h0000};
                use_imm   = 1'b1;
                reg_write = 1'b1;
                dest      = instr[20:16];
            end
            `CPU_OP_LW: begin
                use_imm   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
                dest      = instr[20:16];
            end
            `CPU_OP_SW: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            `CPU_OP_BEQ: is_beq = 1'b1;
            `CPU_OP_BNE: is_bne = 1'b1;
            `CPU_OP_J:   is_j   = 1'b1;
            default: ;
        endcase
    end

    assign issue     = !halt_q;
    assign br_target = pc_plus4 + {imm_val[29:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], instr[25:0], 2'b00};
    assign taken     = (is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc_q     <= `CPU_RESET_PC;
            halt_q   <= 1'b0;
            dec_ex_q <= '0;
        end else begin
            if (issue && !is_break) begin
                if (is_j) begin
                    pc_q <= j_target;
                end else if (taken) begin
                    pc_q <= br_target;
                end else begin
                    pc_q <= pc_plus4;
                end
            end
            if (issue && is_break) begin
                halt_q <= 1'b1;  // pc stays on the break
            end
            dec_ex_q.valid     <= issue;
            dec_ex_q.alu_op    <= alu_op;
            dec_ex_q.op_a      <= rs_val;
            dec_ex_q.op_b      <= use_imm ? imm_val : rt_val;
            dec_ex_q.st_data   <= rt_val;
            dec_ex_q.mem_read  <= mem_read;
            dec_ex_q.mem_write <= mem_write;
            dec_ex_q.reg_write <= reg_write;
            dec_ex_q.dest      <= dest;
            dec_ex_q.is_break  <= is_break;
        end
    end

    assign dec_ex_o = dec_ex_q;

    // program load only while the core is held in reset
    a_prog_in_reset: assert property (@(posedge clk) resetn |-> !prog_we_i)
        else $error("program write outside reset");

endmodule

/* source/execute_stage.sv */
// ALU, execute forwarding path and the register toward the result stage
`timescale 1ns/1ns

module execute_stage (
    input  logic             clk,
    input  logic             resetn,
    input  cpu_pkg::dec_ex_t dec_ex_i,
    output cpu_pkg::ex_res_t ex_res_o,
    output cpu_pkg::fwd_t    ex_fwd_o
);
    import cpu_pkg::*;

    word_t   alu_res;
    ex_res_t ex_res_q;

    always_comb begin
        case (dec_ex_i.alu_op)
            ALU_ADD: alu_res = dec_ex_i.op_a + dec_ex_i.op_b;
            ALU_SUB: alu_res = dec_ex_i.op_a - dec_ex_i.op_b;
            ALU_AND: alu_res = dec_ex_i.op_a & dec_ex_i.op_b;
            ALU_OR:  alu_res = dec_ex_i.op_a | dec_ex_i.op_b;
            ALU_XOR: alu_res = dec_ex_i.op_a ^ dec_ex_i.op_b;
            ALU_SLT: alu_res = {31'd0, $signed(dec_ex_i.op_a) < $signed(dec_ex_i.op_b)};
            ALU_LUI: alu_res = dec_ex_i.op_b;
            default: alu_res = '0;
        endcase
    end

    // load data is not ready yet, so loads are not offered here
    assign ex_fwd_o.we   = dec_ex_i.valid && dec_ex_i.reg_write && !dec_ex_i.mem_read;
    assign ex_fwd_o.addr = dec_ex_i.dest;
    assign ex_fwd_o.data = alu_res;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_res_q <= '0;
        end else begin
            ex_res_q.valid     <= dec_ex_i.valid;
            ex_res_q.alu_res   <= alu_res;
            ex_res_q.st_data   <= dec_ex_i.st_data;
            ex_res_q.mem_read  <= dec_ex_i.mem_read;
            ex_res_q.mem_write <= dec_ex_i.mem_write;
            ex_res_q.reg_write <= dec_ex_i.reg_write;
            ex_res_q.dest      <= dec_ex_i.dest;
            ex_res_q.is_break  <= dec_ex_i.is_break;
        end
    end

    assign ex_res_o = ex_res_q;

    // decoder only issues the seven defined operations
    a_alu_op_legal: assert property (@(posedge clk) disable iff (!resetn)
        dec_ex_i.valid |-> dec_ex_i.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
                                                   ALU_XOR, ALU_SLT, ALU_LUI})
        else $error("illegal alu op issued");

endmodule

/* source/result_stage.sv */
// data memory, LED register, writeback select and the halted flag
`timescale 1ns/1ns
`include "cpu_params.svh"

module result_stage (
    input  logic                      clk,
    input  logic                      resetn,
    input  cpu_pkg::ex_res_t          ex_res_i,
    output cpu_pkg::wb_t              wb_o,
    output cpu_pkg::fwd_t             res_fwd_o,
    output logic [`CPU_LED_WIDTH-1:0] led_o,
    output logic                      halted_o
);
    import cpu_pkg::*;

    localparam int DMEM_AW = $clog2(`CPU_DMEM_DEPTH);

    word_t                     dmem_q [`CPU_DMEM_DEPTH];
    logic [DMEM_AW-1:0]        dmem_idx;
    logic                      is_led;
    logic                      store;
    word_t                     ld_data;
    word_t                     wb_data;
    logic                      wb_we;
    logic [`CPU_LED_WIDTH-1:0] led_q;
    logic                      halted_q;

    assign dmem_idx = ex_res_i.alu_res[DMEM_AW+1:2];  // word index
    assign is_led   = ex_res_i.alu_res == `CPU_LED_ADDR;
    assign store    = ex_res_i.valid && ex_res_i.mem_write;
    assign ld_data  = dmem_q[dmem_idx];

    always_ff @(posedge clk) begin
        if (store && !is_led) begin
            dmem_q[dmem_idx] <= ex_res_i.st_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            led_q    <= '0;
            halted_q <= 1'b0;
        end else begin
            if (store && is_led) begin
                led_q <= ex_res_i.st_data[`CPU_LED_WIDTH-1:0];
            end
            if (ex_res_i.valid && ex_res_i.is_break) begin
                halted_q <= 1'b1;  // sticky until reset
            end
        end
    end

    assign wb_we   = ex_res_i.valid && ex_res_i.reg_write;
    assign wb_data = ex_res_i.mem_read ? ld_data : ex_res_i.alu_res;

    assign wb_o      = '{we: wb_we, addr: ex_res_i.dest, data: wb_data};
    assign res_fwd_o = '{we: wb_we, addr: ex_res_i.dest, data: wb_data};
    assign led_o     = led_q;
    assign halted_o  = halted_q;

    // decode never marks one instruction as both load and store
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(ex_res_i.mem_read && ex_res_i.mem_write))
        else $error("load and store on the same instruction");

endmodule

/* source/cpu_top.sv */
// top level of the three-stage core: decode, register file, execute and result
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpu_top (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      prog_we_i,
    input  cpu_pkg::imem_addr_t       prog_addr_i,
    input  cpu_pkg::word_t            prog_data_i,
    input  cpu_pkg::reg_addr_t        view_sel_i,
    output cpu_pkg::word_t            view_data_o,
    output logic [`CPU_LED_WIDTH-1:0] led_o,
    output logic                      halted_o
);
    import cpu_pkg::*;

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    dec_ex_t   dec_ex;
    ex_res_t   ex_res;
    fwd_t      ex_fwd;
    fwd_t      res_fwd;
    wb_t       wb;

    decode_stage i_decode_stage (
        .clk         (clk),
        .resetn      (resetn),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .rs_data_i   (rs_data),
        .rt_data_i   (rt_data),
        .ex_fwd_i    (ex_fwd),
        .res_fwd_i   (res_fwd),
        .rs_addr_o   (rs_addr),
        .rt_addr_o   (rt_addr),
        .dec_ex_o    (dec_ex)
    );

    reg_file i_reg_file (
        .clk         (clk),
        .resetn      (resetn),
        .rs_addr_i   (rs_addr),
        .rt_addr_i   (rt_addr),
        .wb_i        (wb),
        .view_sel_i  (view_sel_i),
        .rs_data_o   (rs_data),
        .rt_data_o   (rt_data),
        .view_data_o (view_data_o)
    );

    execute_stage i_execute_stage (
        .clk      (clk),
        .resetn   (resetn),
        .dec_ex_i (dec_ex),
        .ex_res_o (ex_res),
        .ex_fwd_o (ex_fwd)
    );

    result_stage i_result_stage (
        .clk       (clk),
        .resetn    (resetn),
        .ex_res_i  (ex_res),
        .wb_o      (wb),
        .res_fwd_o (res_fwd),
        .led_o     (led_o),
        .halted_o  (halted_o)
    );

endmodule

/* testbench/tb_cpu.sv */
// testbench for cpu_top with program load in reset, reset state, run to halt, register and LED checks
`timescale 1ns/1ns
`include "cpu_params.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int PROG_WORDS   = 64;
    localparam int EXP_BASE     = 64;   // register number and value pairs
    localparam int NUM_REGS     = 32;
    localparam int LED_IDX      = 128;
    localparam int TIMEOUT_IDX  = 129;
    localparam int STIM_DEPTH   = 256;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_CYCLES = 8;    // lets anything behind the break show up

    logic                      clk;
    logic                      resetn;
    logic                      prog_we;
    imem_addr_t                prog_addr;
    word_t                     prog_data;
    reg_addr_t                 view_sel;
    word_t                     view_data;
    logic [`CPU_LED_WIDTH-1:0] led;
    logic                      halted;

    word_t stim_mem [STIM_DEPTH];

    cpu_top i_dut (
        .clk         (clk),
        .resetn      (resetn),
        .prog_we_i   (prog_we),
        .prog_addr_i (prog_addr),
        .prog_data_i (prog_data),
        .view_sel_i  (view_sel),
        .view_data_o (view_data),
        .led_o       (led),
        .halted_o    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare_value(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // select on a rising edge, sample on the falling edge
    task automatic read_register(reg_addr_t r, output word_t val);
        @(posedge clk);
        view_sel <= r;
        @(negedge clk);
        val = view_data;
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= imem_addr_t'(i);
            prog_data <= stim_mem[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic check_reset_state();
        word_t val;
        @(negedge clk);
        compare_value("led_o", word_t'(led), '0);
        compare_value("halted_o", word_t'(halted), '0);
        for (int i = 0; i < NUM_REGS; i++) begin
            read_register(reg_addr_t'(i), val);
            compare_value($sformatf("view_data_o r%0d", i), val, '0);
        end
    endtask

    task automatic wait_for_halt(int max_cycles);
        int n;
        n = 0;
        while (halted !== 1'b1 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (halted !== 1'b1) begin
            $display("Timeout: the core did not halt within %0d cycles", max_cycles);
            $display("Finished with errors");
            $fatal(1, "halt timeout");
        end
    endtask

    task automatic check_results();
        reg_addr_t r;
        word_t     val;
        compare_value("halted_o", word_t'(halted), 32'd1);
        compare_value("led_o", word_t'(led), stim_mem[LED_IDX]);
        for (int i = 0; i < NUM_REGS; i++) begin
            r = reg_addr_t'(stim_mem[EXP_BASE + 2 * i]);
            read_register(r, val);
            compare_value($sformatf("view_data_o r%0d", r), val, stim_mem[EXP_BASE + 2 * i + 1]);
        end
    endtask

    initial begin
        resetn    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        view_sel  = '0;
        for (int i = 0; i < STIM_DEPTH; i++) begin
            stim_mem[i] = '0;  // unused program slots become nops
        end
        $readmemh("testbench/program_input.txt", stim_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        load_program();
        check_reset_state();

        @(posedge clk);
        resetn <= 1'b1;

        wait_for_halt(int'(stim_mem[TIMEOUT_IDX]));
        repeat (DRAIN_CYCLES) @(negedge clk);
        check_results();

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* testbench/program_input.txt */
// @00 program words, @40 pairs of register number and expected value
// @80 expected led value, then the run timeout in cycles
@00
3c011234 34215678 24020064 2403fffd  // lui r1, ori r1, addiu r2, addiu r3
00222021 00832823 00a13024 00c23825  // addu r4, subu r5, and r6, or r7
00e14026 0062482a 0043502a ac010040  // xor r8, slt r9, slt r10, sw r1 to 0x40
ac040044 8c0b0040 8c0c0044 00000000  // sw r4 to 0x44, lw r11, lw r12, nop
016c6821 11200001 240e0011 15200002  // addu r13, beq not taken, addiu r14, bne taken
240f0001 24100001 11ce0001 24110001  // skipped r15, skipped r16, beq taken, skipped r17
14420001 24120022 0800001c 24130001  // bne not taken, addiu r18, j, skipped r19
24141000 ae810000 0000000d 24150001  // addiu r20, sw to leds, break, r21 after break
ae820000                             // led store after break
@40
00 00000000 01 12345678
02 00000064 03 fffffffd
04 123456dc 05 123456df
06 12345658 07 1234567c
08 00000004 09 00000001
0a 00000000 0b 12345678
0c 123456dc 0d 2468ad54
0e 00000011 0f 00000000
10 00000000 11 00000000
12 00000022 13 00000000
14 00001000 15 00000000
16 00000000 17 00000000
18 00000000 19 00000000
1a 00000000 1b 00000000
1c 00000000 1d 00000000
1e 00000000 1f 00000000
@80
00005678 00000190

/* vlog.f */
+incdir+source
source/cpu_pkg.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/cpu_top.sv
testbench/tb_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds tb_cpu with Verilator, runs it and checks the log for the pass message

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 -f vlog.f --top-module tb_cpu \
    -Mdir "$BUILD_DIR" -o tb_cpu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/tb_cpu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
